/* list.f */
rtl/iq_des_pkg.sv
rtl/iq_lane_track.sv
rtl/iq_quad_pack.sv
rtl/iq_quad_out.sv
rtl/iq_quad_des.sv
verif/iq_quad_des_properties.sv
verif/tb_iq_quad_des.sv

/* Makefile */
# Verilator build and run of the I/Q quad deserializer testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_iq_quad_des
	out="$$(./obj_dir/Vtb_iq_quad_des)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* verif/iq_testdata.hex */
// columns: test (2 hex), sample I then Q (8 hex), tlast (1 hex), idle gap before beat (1 hex)
// one line per input beat, tests 2 to 5
021001EFFE00
021002EFFD00
021003EFFC00
021004EFFB00
021005EFFA00
021006EFF900
021007EFF800
021008EFF710
0320A1DF5E00
0320A2DF5D00
0320A3DF5C00
0320A4DF5B00
0320A5DF5A00
0320A6DF5910
033B010C0F00
033B020C0E00
033B030C0D00
033B040C0C10
0440007FFF02
04400180FE01
04400281FD03
04400382FC00
04400483FB02
04400584FA01
04400685F903
04400786F812
055A5AA5A500
055A5BA5A400
055A5CA5A300
055A5DA5A200
055A5EA5A100
055A5FA5A000
055A60A59F00
055A61A59E00
055A62A59D00
055A63A59C00
055A64A59B00
055A65A59A10

/* verif/tb_iq_quad_des.sv */
// tb_iq_quad_des: file-driven testbench for the I/Q quad deserializer with word model
`default_nettype none
`timescale 1ns/1ns

module tb_iq_quad_des;

  ////////////////////////////////////////////////////////////////////////////
  // constants and signals
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_LINES  = 38;
  // three register stages from sample to master stream
  localparam int PIPE_DEPTH = 3;
  localparam int GAP_MARGIN = 8;
  localparam logic [1:0] READY_HIGH = 2'd0;
  localparam logic [1:0] READY_RAND = 2'd1;
  localparam logic [1:0] READY_LOW  = 2'd2;

  logic                     m_axis_clk;
  logic                     rst;
  logic                     s_axis_tvalid;
  logic                     s_axis_tready;
  iq_des_pkg::sample_t      s_axis_tdata;
  logic                     s_axis_tlast;
  logic                     m_axis_tvalid;
  logic                     m_axis_tready;
  iq_des_pkg::quad_t        m_axis_tdata;
  logic                     m_axis_tlast;
  iq_des_pkg::drop_count_t  drop_count;

  // test[47:40] sample[39:8] tlast[4] gap[3:0]
  logic [47:0]  testdata [0:NUM_LINES-1];
  // {tlast, data} in transfer order
  logic [128:0] exp_q [$];
  logic [1:0]   ready_mode;
  logic [31:0]  lfsr_state = 32'h6338_1980;

  int errors;
  int checks;
  int test_errors;
  int words_seen;

  iq_quad_des DUT (.*);

  always #5 m_axis_clk = ~m_axis_clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // right-shifting galois form
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
      test_errors++;
    end
  endtask

  // packing rule applied to lines [first, stop)
  // stalled output keeps the hold slot full after the first word
  task automatic build_expected(input int first, input int stop, input logic stalled,
                                output int drops);
    int           i;
    int           lane;
    logic         hold_full;
    logic [127:0] word;
    logic         tl;
    lane      = 0;
    hold_full = 1'b0;
    word      = '0;
    drops     = 0;
    for (i = first; i < stop; i++) begin
      tl = testdata[i][4];
      word[lane*iq_des_pkg::SAMPLE_WIDTH +: iq_des_pkg::SAMPLE_WIDTH] = testdata[i][39:8];
      if (lane == iq_des_pkg::LANES - 1 || tl) begin
        if (hold_full) begin
          drops++;
        end else begin
          exp_q.push_back({tl, word});
          hold_full = stalled;
        end
        // unwritten lanes stay zero
        word = '0;
        lane = 0;
      end else begin
        lane++;
      end
    end
  endtask

  task automatic drive_beat(input logic [47:0] line);
    repeat (int'(line[3:0])) begin
      @(posedge m_axis_clk);
      s_axis_tvalid <= 1'b0;
    end
    @(posedge m_axis_clk);
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= line[39:8];
    s_axis_tlast  <= line[4];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // ready driver and output monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge m_axis_clk) begin
    if (ready_mode == READY_HIGH) begin
      m_axis_tready <= 1'b1;
    end else if (ready_mode == READY_LOW) begin
      m_axis_tready <= 1'b0;
    end else if (!m_axis_tready) begin
      // never low two cycles running
      m_axis_tready <= 1'b1;
    end else begin
      m_axis_tready <= lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  end

  always @(posedge m_axis_clk) begin
    logic [128:0] exp_word;
    // every offered sample must be taken
    if (!rst && s_axis_tvalid) begin
      check_value("s_axis_tready", 128'(s_axis_tready), 128'(1'b1));
    end
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        $display("unexpected word %h on the master stream at %0t", m_axis_tdata, $time);
        errors++;
        test_errors++;
      end else begin
        exp_word = exp_q.pop_front();
        check_value("m_axis_tdata", m_axis_tdata, exp_word[127:0]);
        check_value("m_axis_tlast", 128'(m_axis_tlast), 128'(exp_word[128]));
        words_seen++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                      idx;
    int                      stop;
    int                      i;
    int                      exp_drops;
    int                      tests;
    logic [7:0]              cur_test;
    logic [1:0]              mode;
    iq_des_pkg::drop_count_t drop_base;
    m_axis_clk    = 1'b0;
    rst           = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    ready_mode    = READY_LOW;
    errors        = 0;
    checks        = 0;
    test_errors   = 0;
    words_seen    = 0;
    tests         = 1;
    $readmemh("verif/iq_testdata.hex", testdata);

    // reset state held for ten cycles
    repeat (10) begin
      @(posedge m_axis_clk);
      @(negedge m_axis_clk);
      check_value("m_axis_tvalid", 128'(m_axis_tvalid), 128'(1'b0));
      check_value("drop_count", 128'(drop_count), 128'(0));
    end
    @(posedge m_axis_clk);
    rst        <= 1'b0;
    ready_mode <= READY_HIGH;
    repeat (2) begin
      @(negedge m_axis_clk);
      check_value("m_axis_tvalid", 128'(m_axis_tvalid), 128'(1'b0));
      check_value("drop_count", 128'(drop_count), 128'(0));
    end
    $display("test 1 done, reset state, %0d errors", test_errors);

    idx = 0;
    while (idx < NUM_LINES) begin
      cur_test = testdata[idx][47:40];
      stop     = idx;
      while (stop < NUM_LINES && testdata[stop][47:40] == cur_test) begin
        stop++;
      end
      // random ready for the gap test and a stalled output for the drop test
      if (cur_test == 8'd4) begin
        mode = READY_RAND;
      end else if (cur_test == 8'd5) begin
        mode = READY_LOW;
      end else begin
        mode = READY_HIGH;
      end
      ready_mode  <= mode;
      test_errors = 0;
      words_seen  = 0;
      @(negedge m_axis_clk);
      drop_base = drop_count;
      build_expected(idx, stop, mode == READY_LOW, exp_drops);
      for (i = idx; i < stop; i++) begin
        drive_beat(testdata[i]);
      end
      @(posedge m_axis_clk);
      s_axis_tvalid <= 1'b0;
      if (mode == READY_LOW) begin
        // let the last word reach the output stage before releasing
        repeat (PIPE_DEPTH + 1) @(posedge m_axis_clk);
        ready_mode <= READY_HIGH;
      end
      while (exp_q.size() != 0) begin
        @(posedge m_axis_clk);
      end
      // room for any stray word
      repeat (4) @(posedge m_axis_clk);
      @(negedge m_axis_clk);
      check_value("drop_count", 128'(drop_count - drop_base), 128'(exp_drops));
      $display("test %0d done, %0d words, %0d drops, %0d errors",
               cur_test, words_seen, exp_drops, test_errors);
      tests++;
      idx = stop;
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int max_gap;
    int limit;
    max_gap = 0;
    // data file loaded at time zero
    #1;
    for (i = 0; i < NUM_LINES; i++) begin
      if (int'(testdata[i][3:0]) > max_gap) begin
        max_gap = int'(testdata[i][3:0]);
      end
    end
    limit = NUM_LINES * (max_gap + GAP_MARGIN) * 20;
    repeat (limit) @(posedge m_axis_clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/iq_quad_des_properties.sv */
// iq_quad_des_properties: stream protocol assertions bound to the deserializer top level
`default_nettype none
`timescale 1ns/1ns

module iq_quad_des_properties (
  input logic               m_axis_clk,
  input logic               rst,
  input logic               s_axis_tready,
  input logic               m_axis_tvalid,
  input logic               m_axis_tready,
  input iq_des_pkg::quad_t  m_axis_tdata,
  input logic               m_axis_tlast
);

  // stalled word must not change until it is taken
  assert property (@(posedge m_axis_clk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready) |=>
      ($stable(m_axis_tdata) && $stable(m_axis_tlast)))
    else $error("master stream payload changed while stalled");

  // holding register empty once a reset edge is seen
  assert property (@(posedge m_axis_clk) rst |=> !m_axis_tvalid)
    else $error("m_axis_tvalid high during reset");

  // input side never stalls
  assert property (@(posedge m_axis_clk) s_axis_tready)
    else $error("s_axis_tready dropped low");

endmodule

bind iq_quad_des iq_quad_des_properties props (
  .m_axis_clk    (m_axis_clk),
  .rst           (rst),
  .s_axis_tready (s_axis_tready),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tlast  (m_axis_tlast)
);

`default_nettype wire

/* rtl/iq_quad_des.sv */
// iq_quad_des: AXI-stream deserializer packing four I/Q samples into one 128-bit word
`default_nettype none
`timescale 1ns/1ns

module iq_quad_des (
  input  logic                     m_axis_clk,
  input  logic                     rst,

  // slave stream, one sample per beat
  input  logic                     s_axis_tvalid,
  output logic                     s_axis_tready,
  input  iq_des_pkg::sample_t      s_axis_tdata,
  input  logic                     s_axis_tlast,

  // master stream, one quad word per beat
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready,
  output iq_des_pkg::quad_t        m_axis_tdata,
  output logic                     m_axis_tlast,

  output iq_des_pkg::drop_count_t  drop_count
);

  // lane tracker to packer
  logic                    beat_valid;
  iq_des_pkg::iq_beat_t    beat;

  // packer to output stage
  logic                    quad_valid;
  iq_des_pkg::quad_beat_t  quad;

  ////////////////////////////////////////////////////////////////////////////
  // input, packing, output
  ////////////////////////////////////////////////////////////////////////////

  iq_lane_track u_lane_track (
    .m_axis_clk    (m_axis_clk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .beat_valid    (beat_valid),
    .beat          (beat)
  );

  iq_quad_pack u_quad_pack (
    .m_axis_clk (m_axis_clk),
    .rst        (rst),
    .beat_valid (beat_valid),
    .beat       (beat),
    .quad_valid (quad_valid),
    .quad       (quad)
  );

  // holds one word, drops while stalled
  iq_quad_out u_quad_out (
    .m_axis_clk    (m_axis_clk),
    .rst           (rst),
    .quad_valid    (quad_valid),
    .quad          (quad),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .drop_count    (drop_count)
  );

endmodule

`default_nettype wire

/* rtl/iq_quad_out.sv */
// iq_quad_out: master-stream holding register with drop-on-busy policy and drop counter
`default_nettype none
`timescale 1ns/1ns

module iq_quad_out (
  input  logic                     m_axis_clk,
  input  logic                     rst,

  // completed word from the packer
  input  logic                     quad_valid,
  input  iq_des_pkg::quad_beat_t   quad,

  // master stream
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready,
  output iq_des_pkg::quad_t        m_axis_tdata,
  output logic                     m_axis_tlast,

  // saturating count of discarded words
  output iq_des_pkg::drop_count_t  drop_count
);

  // holding register
  logic                    hold_valid;
  iq_des_pkg::quad_beat_t  hold;

  logic transfer;
  logic load;
  logic drop;
  logic drop_sat;

  // handshake on the master side
  assign transfer = hold_valid & m_axis_tready;
  // slot free, or freed this cycle
  assign load     = quad_valid & (~hold_valid | m_axis_tready);
  // slot busy and stalled, new word lost
  assign drop     = quad_valid & hold_valid & ~m_axis_tready;
  assign drop_sat = (drop_count == {iq_des_pkg::DROP_WIDTH{1'b1}});

  ////////////////////////////////////////////////////////////////////////////
  // valid and payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else if (load) begin
      hold_valid <= 1'b1;
    end else if (transfer) begin
      // sent with nothing behind it
      hold_valid <= 1'b0;
    end
  end

  // data and last only change on a load, so stable while stalled
  always_ff @(posedge m_axis_clk) begin
    if (load) begin
      hold <= quad;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // drop counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      drop_count <= '0;
    end else if (drop && !drop_sat) begin
      drop_count <= drop_count + 1'b1;
    end
  end

  assign m_axis_tvalid = hold_valid;
  assign m_axis_tdata  = hold.data;
  assign m_axis_tlast  = hold.last;

endmodule

`default_nettype wire

/* rtl/iq_quad_pack.sv */
// iq_quad_pack: assembles tagged I/Q samples into quad words, zero-filling short bursts
`default_nettype none
`timescale 1ns/1ns

module iq_quad_pack (
  input  logic                    m_axis_clk,
  input  logic                    rst,

  // tagged beat from the lane tracker
  input  logic                    beat_valid,
  input  iq_des_pkg::iq_beat_t    beat,

  // completed word toward the output stage
  output logic                    quad_valid,
  output iq_des_pkg::quad_beat_t  quad
);

  // assembly register, viewed as lane slots
  // slot 0 sits in the low bits of the quad word
  iq_des_pkg::sample_t [iq_des_pkg::LANES-1:0] slots_q;
  iq_des_pkg::sample_t [iq_des_pkg::LANES-1:0] slots_next;

  // beat closes the word
  logic word_done;

  ////////////////////////////////////////////////////////////////////////////
  // slot write and completion
  ////////////////////////////////////////////////////////////////////////////

  // incoming sample merged into the current slots
  always_comb begin
    slots_next = slots_q;
    slots_next[beat.lane] = beat.sample;
  end

  // full on lane 3, short on a burst end
  assign word_done = beat_valid &
                     (beat.last ||
                      (beat.lane == iq_des_pkg::lane_t'(iq_des_pkg::LANES - 1)));

  ////////////////////////////////////////////////////////////////////////////
  // assembly register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      slots_q <= '0;
    end else if (word_done) begin
      // cleared after issue
      // unwritten lanes of a short burst go out as zero
      slots_q <= '0;
    end else if (beat_valid) begin
      slots_q <= slots_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // quad pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      quad_valid <= 1'b0;
    end else begin
      // one cycle per completed word, no ready
      quad_valid <= word_done;
    end
  end

  // word payload, includes the closing sample
  always_ff @(posedge m_axis_clk) begin
    if (word_done) begin
      quad.data <= iq_des_pkg::quad_t'(slots_next);
      // last follows the closing beat
      quad.last <= beat.last;
    end
  end

endmodule

`default_nettype wire

/* rtl/iq_lane_track.sv */
// iq_lane_track: accepts slave-stream samples and tags each with lane index and burst end
`default_nettype none
`timescale 1ns/1ns

module iq_lane_track (
  input  logic                  m_axis_clk,
  input  logic                  rst,

  // slave stream
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  iq_des_pkg::sample_t   s_axis_tdata,
  input  logic                  s_axis_tlast,

  // tagged beat toward the packer
  output logic                  beat_valid,
  output iq_des_pkg::iq_beat_t  beat
);

  // lane the next accepted sample lands in
  iq_des_pkg::lane_t lane_q;
  // last lane of a quad word
  logic              lane_wrap;
  logic              accept;

  // no backpressure on the input side, no fifo either
  assign s_axis_tready = 1'b1;
  assign accept        = s_axis_tvalid & s_axis_tready;
  assign lane_wrap     = (lane_q == iq_des_pkg::lane_t'(iq_des_pkg::LANES - 1));

  ////////////////////////////////////////////////////////////////////////////
  // lane index and beat strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      lane_q     <= '0;
      beat_valid <= 1'b0;
    end else begin
      // one-cycle pulse per accepted sample
      beat_valid <= accept;
      if (accept) begin
        // burst end forces next burst into lane 0
        if (s_axis_tlast || lane_wrap) begin
          lane_q <= '0;
        end else begin
          lane_q <= lane_q + 1'b1;
        end
      end
      // idle cycles hold the lane
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // beat payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (accept) begin
      beat.sample <= s_axis_tdata;
      beat.lane   <= lane_q;
      beat.last   <= s_axis_tlast;
    end
  end

endmodule

`default_nettype wire

/* rtl/iq_des_pkg.sv */
// iq_des_pkg: shared widths, sample and quad types for the I/Q quad deserializer
`default_nettype none

package iq_des_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // one complex sample, I in upper half, Q in lower half
  localparam int SAMPLE_WIDTH = 32;
  // samples per quad word
  localparam int LANES        = 4;
  // full quad word, lane 0 in low bits
  localparam int QUAD_WIDTH   = SAMPLE_WIDTH * LANES;
  // saturating drop counter
  localparam int DROP_WIDTH   = 16;

  ////////////////////////////////////////////////////////////////////////////
  // plain vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [SAMPLE_WIDTH-1:0]     sample_t;
  typedef logic [$clog2(LANES)-1:0]    lane_t;
  typedef logic [QUAD_WIDTH-1:0]       quad_t;
  typedef logic [DROP_WIDTH-1:0]       drop_count_t;

  ////////////////////////////////////////////////////////////////////////////
  // struct types between blocks
  ////////////////////////////////////////////////////////////////////////////

  // tagged sample, lane tracker to packer (35 bits)
  typedef struct packed {
    sample_t sample;
    lane_t   lane;
    logic    last;
  } iq_beat_t;

  // packed word, packer to output stage (129 bits)
  typedef struct packed {
    quad_t data;
    logic  last;
  } quad_beat_t;

endpackage

`default_nettype wire
